// ==== include/csr_gen_cfg.svh ====
// CSR index generator configuration: datapath widths and request FIFO sizing

`ifndef CSR_GEN_CFG_SVH
`define CSR_GEN_CFG_SVH

// ------------------------------
// Datapath widths
// ------------------------------

// Graph index, stride and address offset
`define CSR_INDEX_W 32

// Shift amount applied to the index to form the offset
`define CSR_SHIFT_W 5

// ------------------------------
// Request FIFO
// ------------------------------

// Number of request words held
`define CSR_FIFO_DEPTH 16

// Fill level where prog_full asserts
// Must leave room for the words still in flight behind the sequencer
`define CSR_FIFO_PROG_THRESH 8

`endif

// ==== hdl/csr_gen_pkg.sv ====
// CSR index generator package: shared vector types and the sequencer state encoding

`default_nettype none

`include "csr_gen_cfg.svh"

package csr_gen_pkg;

    // ------------------------------
    // Datapath vectors
    // ------------------------------

    // Graph index, stride or address offset
    typedef logic [`CSR_INDEX_W-1:0] csr_index_t;

    // Left or right shift amount for the offset
    typedef logic [`CSR_SHIFT_W-1:0] csr_shift_t;

    // ------------------------------
    // Sequencer FSM
    // ------------------------------

    // RESET runs once after reset release
    // SETUP loads the counter, START lets it settle
    // The TRANS states give one cycle around a pause
    typedef enum logic [3:0] {
        RESET,
        IDLE,
        SETUP,
        START,
        BUSY,
        PAUSE_TRANS,
        PAUSE,
        BUSY_TRANS,
        DONE
    } csr_seq_state_t;

endpackage : csr_gen_pkg

`default_nettype wire

// ==== hdl/csr_config_capture.sv ====
// CSR config capture: latches one run configuration while the sequencer is idle

`timescale 1ns/10ps
`default_nettype none

module csr_config_capture (
    input  wire logic                   ap_clk,
    input  wire logic                   areset_engine,
    input  wire logic                   cfg_valid,
    input  wire csr_gen_pkg::csr_index_t cfg_index_start,
    input  wire csr_gen_pkg::csr_index_t cfg_index_end,
    input  wire csr_gen_pkg::csr_index_t cfg_stride,
    input  wire logic                   cfg_shift_left,
    input  wire csr_gen_pkg::csr_shift_t cfg_shift_amount,
    input  wire logic                   seq_idle,
    output logic                        cfg_loaded,
    output csr_gen_pkg::csr_index_t     index_start,
    output csr_gen_pkg::csr_index_t     index_end,
    output csr_gen_pkg::csr_index_t     stride,
    output logic                        shift_left,
    output csr_gen_pkg::csr_shift_t     shift_amount
);

    // Only one configuration per run, taken while idle
    logic accept;

    assign accept = cfg_valid & seq_idle & ~cfg_loaded;

    // ------------------------------
    // Load flag
    // ------------------------------

    // Stays up until the sequencer leaves IDLE
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            cfg_loaded <= 1'b0;
        end else if (accept) begin
            cfg_loaded <= 1'b1;
        end else if (!seq_idle) begin
            cfg_loaded <= 1'b0;
        end
    end

    // ------------------------------
    // Held fields
    // ------------------------------

    // Frozen for the whole run, later pulses are dropped
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            index_start  <= cfg_index_start;
            index_end    <= cfg_index_end;
            stride       <= cfg_stride;
            shift_left   <= cfg_shift_left;
            shift_amount <= cfg_shift_amount;
        end
    end

endmodule : csr_config_capture

`default_nettype wire

// ==== hdl/csr_index_sequencer.sv ====
// CSR index sequencer: FSM and stride counter that emit one index strobe per edge

`timescale 1ns/10ps
`default_nettype none

module csr_index_sequencer (
    input  wire logic                   ap_clk,
    input  wire logic                   areset_engine,
    input  wire logic                   cfg_loaded,
    input  wire csr_gen_pkg::csr_index_t index_start,
    input  wire csr_gen_pkg::csr_index_t index_end,
    input  wire csr_gen_pkg::csr_index_t stride,
    input  wire logic                   pause,
    input  wire logic                   fifo_prog_full,
    output logic                        seq_idle,
    output logic                        index_strobe,
    output csr_gen_pkg::csr_index_t     index,
    output logic                        ready,
    output logic                        done
);

    csr_gen_pkg::csr_seq_state_t state;
    csr_gen_pkg::csr_seq_state_t next_state;

    // Stride counter, loaded in SETUP
    csr_gen_pkg::csr_index_t count;

    logic pause_reg;
    logic below_end;
    logic emit;

    // Strictly below the end, so start >= end emits nothing
    assign below_end = (count < index_end);
    assign emit      = (state == csr_gen_pkg::BUSY) & below_end;

    // Idle once ready has caught up with the state
    assign seq_idle = (state == csr_gen_pkg::IDLE) & ready;

    // ------------------------------
    // Pause sampling
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            pause_reg <= 1'b0;
        end else begin
            pause_reg <= pause;
        end
    end

    // ------------------------------
    // State register and next state
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= csr_gen_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            csr_gen_pkg::RESET: begin
                next_state = csr_gen_pkg::IDLE;
            end
            csr_gen_pkg::IDLE: begin
                if (cfg_loaded) begin
                    next_state = csr_gen_pkg::SETUP;
                end
            end
            csr_gen_pkg::SETUP: begin
                next_state = csr_gen_pkg::START;
            end
            csr_gen_pkg::START: begin
                next_state = csr_gen_pkg::BUSY;
            end
            csr_gen_pkg::BUSY: begin
                // End check wins over back-pressure
                if (!below_end) begin
                    next_state = csr_gen_pkg::DONE;
                end else if (fifo_prog_full | pause_reg) begin
                    next_state = csr_gen_pkg::PAUSE_TRANS;
                end
            end
            csr_gen_pkg::PAUSE_TRANS: begin
                next_state = csr_gen_pkg::PAUSE;
            end
            csr_gen_pkg::PAUSE: begin
                if (!fifo_prog_full && !pause_reg) begin
                    next_state = csr_gen_pkg::BUSY_TRANS;
                end
            end
            csr_gen_pkg::BUSY_TRANS: begin
                next_state = csr_gen_pkg::BUSY;
            end
            csr_gen_pkg::DONE: begin
                next_state = csr_gen_pkg::IDLE;
            end
            default: begin
                next_state = csr_gen_pkg::RESET;
            end
        endcase
    end

    // ------------------------------
    // Status levels
    // ------------------------------

    // One cycle behind the state
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            ready <= 1'b0;
            done  <= 1'b1;
        end else begin
            ready <= (state == csr_gen_pkg::IDLE);
            done  <= (state == csr_gen_pkg::IDLE) | (state == csr_gen_pkg::DONE) |
                     (state == csr_gen_pkg::RESET);
        end
    end

    // ------------------------------
    // Counter and index strobe
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            index_strobe <= 1'b0;
        end else begin
            index_strobe <= emit;
        end
    end

    // Counter only moves on an emitted index, so a pause loses nothing
    always_ff @(posedge ap_clk) begin
        if (state == csr_gen_pkg::SETUP) begin
            count <= index_start;
        end else if (emit) begin
            count <= count + stride;
        end
        if (emit) begin
            index <= count;
        end
    end

endmodule : csr_index_sequencer

`default_nettype wire

// ==== hdl/csr_request_formatter.sv ====
// CSR request formatter: registers each index with its shifted address offset

`timescale 1ns/10ps
`default_nettype none

module csr_request_formatter (
    input  wire logic                   ap_clk,
    input  wire logic                   areset_engine,
    input  wire logic                   index_strobe,
    input  wire csr_gen_pkg::csr_index_t index,
    input  wire logic                   shift_left,
    input  wire csr_gen_pkg::csr_shift_t shift_amount,
    output logic                        push,
    output csr_gen_pkg::csr_index_t     push_index,
    output csr_gen_pkg::csr_index_t     push_offset
);

    csr_gen_pkg::csr_index_t offset;

    // ------------------------------
    // Offset
    // ------------------------------

    // Logical shift, zeros fill in from either side
    always_comb begin
        if (shift_left) begin
            offset = index << shift_amount;
        end else begin
            offset = index >> shift_amount;
        end
    end

    // ------------------------------
    // Output stage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            push <= 1'b0;
        end else begin
            push <= index_strobe;
        end
    end

    // Payload follows the strobe
    always_ff @(posedge ap_clk) begin
        if (index_strobe) begin
            push_index  <= index;
            push_offset <= offset;
        end
    end

endmodule : csr_request_formatter

`default_nettype wire

// ==== hdl/csr_request_fifo.sv ====
// CSR request FIFO: synchronous circular buffer with programmable full and read valid

`timescale 1ns/10ps
`default_nettype none

`include "csr_gen_cfg.svh"

module csr_request_fifo (
    input  wire logic                   ap_clk,
    input  wire logic                   areset_engine,
    input  wire logic                   push,
    input  wire csr_gen_pkg::csr_index_t push_index,
    input  wire csr_gen_pkg::csr_index_t push_offset,
    input  wire logic                   pop_request,
    output logic                        prog_full,
    output logic                        empty,
    output logic                        request_valid,
    output csr_gen_pkg::csr_index_t     request_index,
    output csr_gen_pkg::csr_index_t     request_offset
);

    localparam int ADDR_W  = $clog2(`CSR_FIFO_DEPTH);
    localparam int COUNT_W = ADDR_W + 1;

    csr_gen_pkg::csr_index_t mem_index  [`CSR_FIFO_DEPTH];
    csr_gen_pkg::csr_index_t mem_offset [`CSR_FIFO_DEPTH];

    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    assign full      = (count == COUNT_W'(`CSR_FIFO_DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= COUNT_W'(`CSR_FIFO_PROG_THRESH));

    // A push into a full buffer is dropped
    assign wr_en = push & ~full;
    assign rd_en = pop_request & ~empty;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ADDR_W'(`CSR_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ADDR_W'(`CSR_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // ------------------------------
    // Storage and read port
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem_index[wr_ptr]  <= push_index;
            mem_offset[wr_ptr] <= push_offset;
        end
        if (rd_en) begin
            request_index  <= mem_index[rd_ptr];
            request_offset <= mem_offset[rd_ptr];
        end
    end

    // Valid one cycle after the pop
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            request_valid <= 1'b0;
        end else begin
            request_valid <= rd_en;
        end
    end

endmodule : csr_request_fifo

`default_nettype wire

// ==== hdl/csr_index_generator.sv ====
// CSR index generator top level wiring config capture, sequencer, formatter and request FIFO

`timescale 1ns/10ps
`default_nettype none

module csr_index_generator (
    input  wire logic                   ap_clk,
    input  wire logic                   areset_engine,
    input  wire logic                   cfg_valid,
    input  wire csr_gen_pkg::csr_index_t cfg_index_start,
    input  wire csr_gen_pkg::csr_index_t cfg_index_end,
    input  wire csr_gen_pkg::csr_index_t cfg_stride,
    input  wire logic                   cfg_shift_left,
    input  wire csr_gen_pkg::csr_shift_t cfg_shift_amount,
    input  wire logic                   pause,
    input  wire logic                   request_rd_en,
    output logic                        request_valid,
    output csr_gen_pkg::csr_index_t     request_index,
    output csr_gen_pkg::csr_index_t     request_offset,
    output logic                        ready,
    output logic                        done
);

    // ------------------------------
    // Stage wiring
    // ------------------------------

    // Held configuration
    logic                    cfg_loaded;
    csr_gen_pkg::csr_index_t index_start;
    csr_gen_pkg::csr_index_t index_end;
    csr_gen_pkg::csr_index_t stride;
    logic                    shift_left;
    csr_gen_pkg::csr_shift_t shift_amount;

    // Sequencer to formatter
    logic                    seq_idle;
    logic                    index_strobe;
    csr_gen_pkg::csr_index_t index;

    // Formatter to FIFO
    logic                    push;
    csr_gen_pkg::csr_index_t push_index;
    csr_gen_pkg::csr_index_t push_offset;

    // FIFO fill level back to the sequencer
    logic fifo_prog_full;

    csr_config_capture csr_config_capture_i (
        .ap_clk           (ap_clk),
        .areset_engine    (areset_engine),
        .cfg_valid        (cfg_valid),
        .cfg_index_start  (cfg_index_start),
        .cfg_index_end    (cfg_index_end),
        .cfg_stride       (cfg_stride),
        .cfg_shift_left   (cfg_shift_left),
        .cfg_shift_amount (cfg_shift_amount),
        .seq_idle         (seq_idle),
        .cfg_loaded       (cfg_loaded),
        .index_start      (index_start),
        .index_end        (index_end),
        .stride           (stride),
        .shift_left       (shift_left),
        .shift_amount     (shift_amount)
    );

    csr_index_sequencer csr_index_sequencer_i (
        .ap_clk         (ap_clk),
        .areset_engine  (areset_engine),
        .cfg_loaded     (cfg_loaded),
        .index_start    (index_start),
        .index_end      (index_end),
        .stride         (stride),
        .pause          (pause),
        .fifo_prog_full (fifo_prog_full),
        .seq_idle       (seq_idle),
        .index_strobe   (index_strobe),
        .index          (index),
        .ready          (ready),
        .done           (done)
    );

    csr_request_formatter csr_request_formatter_i (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .index_strobe  (index_strobe),
        .index         (index),
        .shift_left    (shift_left),
        .shift_amount  (shift_amount),
        .push          (push),
        .push_index    (push_index),
        .push_offset   (push_offset)
    );

    // Consumer read enable drives the pop directly
    csr_request_fifo csr_request_fifo_i (
        .ap_clk         (ap_clk),
        .areset_engine  (areset_engine),
        .push           (push),
        .push_index     (push_index),
        .push_offset    (push_offset),
        .pop_request    (request_rd_en),
        .prog_full      (fifo_prog_full),
        .empty          (),
        .request_valid  (request_valid),
        .request_index  (request_index),
        .request_offset (request_offset)
    );

endmodule : csr_index_generator

`default_nettype wire

// ==== verif/csr_index_generator_tb.sv ====
// CSR index generator testbench driving run configurations and checking words against a reference

`timescale 1ns/10ps
`default_nettype none

`include "csr_gen_cfg.svh"

module csr_index_generator_tb;

    localparam int INDEX_W = `CSR_INDEX_W;
    localparam int SHIFT_W = `CSR_SHIFT_W;

    // Traffic modes for pause and request_rd_en
    localparam int DRAIN  = 0;
    localparam int STALL  = 1;
    localparam int RANDOM = 2;

    logic                    ap_clk = 1'b0;
    logic                    areset_engine;
    logic                    cfg_valid;
    csr_gen_pkg::csr_index_t cfg_index_start;
    csr_gen_pkg::csr_index_t cfg_index_end;
    csr_gen_pkg::csr_index_t cfg_stride;
    logic                    cfg_shift_left;
    csr_gen_pkg::csr_shift_t cfg_shift_amount;
    logic                    pause;
    logic                    request_rd_en;
    logic                    request_valid;
    csr_gen_pkg::csr_index_t request_index;
    csr_gen_pkg::csr_index_t request_offset;
    logic                    ready;
    logic                    done;

    // Reference words with the oldest first
    csr_gen_pkg::csr_index_t ref_index[$];
    csr_gen_pkg::csr_index_t ref_offset[$];

    string test_name;
    int    traffic;
    int    since_cfg;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;

    always #2 ap_clk = ~ap_clk;

    csr_index_generator csr_index_generator_i (
        .ap_clk           (ap_clk),
        .areset_engine    (areset_engine),
        .cfg_valid        (cfg_valid),
        .cfg_index_start  (cfg_index_start),
        .cfg_index_end    (cfg_index_end),
        .cfg_stride       (cfg_stride),
        .cfg_shift_left   (cfg_shift_left),
        .cfg_shift_amount (cfg_shift_amount),
        .pause            (pause),
        .request_rd_en    (request_rd_en),
        .request_valid    (request_valid),
        .request_index    (request_index),
        .request_offset   (request_offset),
        .ready            (ready),
        .done             (done)
    );

    // ------------------------------
    // Checking
    // ------------------------------

    task automatic check_bit(string what, logic want, logic got);
        assert (got === want) else begin
            $display("ERR %s: %s expected %b, actual %b", test_name, what, want, got);
            errors++;
        end
    endtask

    // Each popped word against the head of the reference
    task automatic check_outputs();
        csr_gen_pkg::csr_index_t want_index;
        csr_gen_pkg::csr_index_t want_offset;
        if (request_valid) begin
            assert (ref_index.size() > 0) else begin
                $display("%s: a request word arrived that no run should produce", test_name);
                errors++;
            end
            if (ref_index.size() > 0) begin
                want_index  = ref_index.pop_front();
                want_offset = ref_offset.pop_front();
                assert (request_index == want_index) else begin
                    $display("ERR %s: index expected %0d, actual %0d",
                             test_name, want_index, request_index);
                    errors++;
                end
                assert (request_offset == want_offset) else begin
                    $display("ERR %s: offset expected %0d, actual %0d",
                             test_name, want_offset, request_offset);
                    errors++;
                end
            end
            assert (since_cfg >= 5) else begin
                $display("%s: word arrived only %0d cycles after the config", test_name,
                         since_cfg);
                errors++;
            end
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    // One clock with drive on the rising edge and sampling on the falling edge
    task automatic step();
        @(posedge ap_clk);
        cfg_valid <= 1'b0;
        case (traffic)
            DRAIN: begin
                pause         <= 1'b0;
                request_rd_en <= 1'b1;
            end
            STALL: begin
                pause         <= 1'b0;
                request_rd_en <= 1'b0;
            end
            default: begin
                pause         <= (($urandom % 4) == 0);
                request_rd_en <= (($urandom % 3) != 0);
            end
        endcase
        since_cfg++;
        @(negedge ap_clk);
        check_outputs();
    endtask

    // Index sequence from start in stride steps while strictly below the end
    task automatic queue_reference(csr_gen_pkg::csr_index_t start, csr_gen_pkg::csr_index_t stop,
                                   csr_gen_pkg::csr_index_t stride, logic shl,
                                   csr_gen_pkg::csr_shift_t amt);
        csr_gen_pkg::csr_index_t idx;
        idx = start;
        while (idx < stop) begin
            ref_index.push_back(idx);
            if (shl) begin
                ref_offset.push_back(idx << amt);
            end else begin
                ref_offset.push_back(idx >> amt);
            end
            idx = idx + stride;
        end
    endtask

    task automatic send_config(csr_gen_pkg::csr_index_t start, csr_gen_pkg::csr_index_t stop,
                               csr_gen_pkg::csr_index_t stride, logic shl,
                               csr_gen_pkg::csr_shift_t amt, logic accepted);
        if (accepted) begin
            queue_reference(start, stop, stride, shl, amt);
            since_cfg = 0;
        end
        @(posedge ap_clk);
        cfg_valid        <= 1'b1;
        cfg_index_start  <= start;
        cfg_index_end    <= stop;
        cfg_stride       <= stride;
        cfg_shift_left   <= shl;
        cfg_shift_amount <= amt;
        @(negedge ap_clk);
        check_outputs();
    endtask

    task automatic wait_ready(logic level, int limit, string what);
        int cycles;
        cycles = 0;
        while (ready !== level && cycles < limit) begin
            step();
            cycles++;
        end
        if (ready !== level) begin
            $display("%s: timed out after %0d cycles waiting for %s", test_name, limit, what);
            errors++;
        end
    endtask

    // Run ends with ready back up and every reference word delivered
    task automatic finish_run();
        int cycles;
        wait_ready(1'b0, 20, "ready to fall");
        cycles = 0;
        while (!(ready && ref_index.size() == 0) && cycles < 4000) begin
            step();
            cycles++;
        end
        if (!(ready && ref_index.size() == 0)) begin
            $display("%s: timed out with %0d words never delivered", test_name, ref_index.size());
            errors++;
            ref_index.delete();
            ref_offset.delete();
        end
        check_bit("done at end of run", 1'b1, done);
        // Late extra words would show up here
        repeat (6) step();
    endtask

    task automatic begin_test(string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - errors_at_start);
        end else begin
            $display("%s: ok", test_name);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        csr_gen_pkg::csr_index_t start;
        csr_gen_pkg::csr_index_t stop;
        csr_gen_pkg::csr_index_t stride;
        logic                    shl;
        csr_gen_pkg::csr_shift_t amt;
        int                      cycles;

        void'($urandom(62));
        areset_engine    = 1'b1;
        cfg_valid        = 1'b0;
        cfg_index_start  = '0;
        cfg_index_end    = '0;
        cfg_stride       = '0;
        cfg_shift_left   = 1'b0;
        cfg_shift_amount = '0;
        pause            = 1'b0;
        request_rd_en    = 1'b0;
        traffic          = DRAIN;
        since_cfg        = 0;
        errors           = 0;
        tests_run        = 0;
        tests_failed     = 0;

        begin_test("reset");
        repeat (10) step();
        check_bit("ready in reset", 1'b0, ready);
        check_bit("done in reset", 1'b1, done);
        @(posedge ap_clk);
        areset_engine <= 1'b0;
        @(negedge ap_clk);
        check_outputs();
        wait_ready(1'b1, 3, "ready after reset");
        check_bit("done after reset", 1'b1, done);
        end_test();

        begin_test("basic_run");
        send_config(4, 20, 3, 1'b1, 2, 1'b1);
        finish_run();
        end_test();

        begin_test("shift_right");
        send_config(1000, 1100, 7, 1'b0, 3, 1'b1);
        finish_run();
        end_test();

        begin_test("empty_run");
        send_config(50, 50, 4, 1'b1, 1, 1'b1);
        finish_run();
        send_config(90, 30, 2, 1'b0, 2, 1'b1);
        finish_run();
        end_test();

        // 40 indices with the consumer stalled until the sequencer has to pause
        begin_test("back_pressure");
        traffic = STALL;
        send_config(100, 300, 5, 1'b1, 4, 1'b1);
        wait_ready(1'b0, 20, "ready to fall");
        cycles = 0;
        while (!csr_index_generator_i.fifo_prog_full && cycles < 200) begin
            step();
            cycles++;
        end
        if (!csr_index_generator_i.fifo_prog_full) begin
            $display("%s: FIFO never reached its threshold of %0d", test_name,
                     `CSR_FIFO_PROG_THRESH);
            errors++;
        end
        repeat (12) step();
        check_bit("ready while stalled", 1'b0, ready);
        check_bit("done while stalled", 1'b0, done);
        traffic = DRAIN;
        finish_run();
        end_test();

        begin_test("random_runs");
        traffic = RANDOM;
        for (int run = 0; run < 8; run++) begin
            start  = INDEX_W'($urandom % 500);
            stop   = start + INDEX_W'($urandom % 120);
            stride = INDEX_W'(1 + ($urandom % 9));
            shl    = (($urandom % 2) == 1);
            amt    = SHIFT_W'($urandom % 32);
            send_config(start, stop, stride, shl, amt, 1'b1);
            finish_run();
        end
        traffic = DRAIN;
        end_test();

        // Pulses while busy must be ignored
        begin_test("config_during_run");
        send_config(0, 60, 2, 1'b1, 1, 1'b1);
        wait_ready(1'b0, 20, "ready to fall");
        repeat (3) step();
        send_config(7, 9000, 1, 1'b0, 5, 1'b0);
        repeat (5) step();
        send_config(3, 40, 11, 1'b1, 9, 1'b0);
        finish_run();
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : csr_index_generator_tb

`default_nettype wire

// ==== build.f ====
+incdir+include
hdl/csr_gen_pkg.sv
hdl/csr_config_capture.sv
hdl/csr_index_sequencer.sv
hdl/csr_request_formatter.sv
hdl/csr_request_fifo.sv
hdl/csr_index_generator.sv
verif/csr_index_generator_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the CSR index generator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f build.f \
    --top-module csr_index_generator_tb \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcsr_index_generator_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation executable exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
